// ==== src/vdp_super_params.svh ====
`ifndef VDP_SUPER_PARAMS_SVH
`define VDP_SUPER_PARAMS_SVH

// total raster, blanking included
`define VDP_FRAME_W_60 858
`define VDP_FRAME_H_60 525
`define VDP_FRAME_W_50 864
`define VDP_FRAME_H_50 625

// active picture
`define VDP_VISIBLE_W    720
`define VDP_VISIBLE_H_60 480
`define VDP_VISIBLE_H_50 576

`define VDP_VRAM_AW 17      // 32-bit words
`define VDP_MID_LINE_PIX 360 // one super_mid source line

// bus window, claimed ahead of a fetched line and released after the read-ahead
`define VDP_BUSY_START_X 852
`define VDP_BUSY_END_X   724

`endif

// ==== src/vdp_super_pkg.sv ====
`include "vdp_super_params.svh"

package vdp_super_pkg;

  typedef logic [9:0] coord_t;
  typedef logic [`VDP_VRAM_AW-1:0] vram_addr_t;
  typedef logic [31:0] vram_word_t;  // pixel 0 in bits 7:0
  typedef logic [7:0] pal_index_t;

  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgb_t;

  typedef enum logic [1:0] {sr_off, sr_mid, sr_res} sr_mode_t;
  typedef enum logic [1:0] {hs_idle, hs_write, hs_ack} host_state_t;

  typedef struct packed {
    coord_t cx;
    coord_t cy;
    logic   last_line;
    logic   visible_line;
  } beam_t;

  localparam logic tgt_vram    = 1'b0;
  localparam logic tgt_palette = 1'b1;

  typedef struct packed {
    logic       target;
    vram_addr_t addr;
    vram_word_t data;  // palette writes use bits 23:0
  } host_cmd_t;

  typedef struct packed {
    logic       en;
    logic       target;
    vram_addr_t addr;
    vram_word_t data;
  } wr_req_t;

  function automatic coord_t frame_width(logic pal_mode);
    return pal_mode ? coord_t'(`VDP_FRAME_W_50) : coord_t'(`VDP_FRAME_W_60);
  endfunction

  function automatic coord_t frame_height(logic pal_mode);
    return pal_mode ? coord_t'(`VDP_FRAME_H_50) : coord_t'(`VDP_FRAME_H_60);
  endfunction

  function automatic coord_t visible_height(logic pal_mode);
    return pal_mode ? coord_t'(`VDP_VISIBLE_H_50) : coord_t'(`VDP_VISIBLE_H_60);
  endfunction

endpackage

// ==== src/raster_timing.sv ====
`include "vdp_super_params.svh"

module raster_timing
  import vdp_super_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  pal_mode,
  output beam_t beam,
  output logic  de,
  output logic  frame_start
);

  coord_t     cx;
  coord_t     cy;
  logic       line_end;
  logic       last_line;
  logic       visible_line;
  logic       next_vis;
  logic       pre_de;
  logic       pre_fs;
  logic [1:0] de_pipe;
  logic [1:0] fs_pipe;

  // >= so a pal_mode change mid-frame still wraps
  assign line_end     = (cx >= frame_width(pal_mode) - 10'd1);
  assign last_line    = (cy >= frame_height(pal_mode) - 10'd1);
  assign visible_line = (cy < visible_height(pal_mode));
  assign next_vis     = last_line || (cy + 10'd1 < visible_height(pal_mode));

  // pixel n is addressed in column n-1, so flag one column ahead
  assign pre_de = (visible_line && cx < `VDP_VISIBLE_W - 1) || (line_end && next_vis);
  assign pre_fs = line_end && last_line;  // pixel 0 of line 0 comes next

  assign beam = '{cx: cx, cy: cy, last_line: last_line, visible_line: visible_line};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cx      <= '0;
      cy      <= '0;
      de_pipe <= '0;
      fs_pipe <= '0;
    end else begin
      if (line_end) begin
        cx <= '0;
        cy <= last_line ? '0 : cy + 10'd1;
      end else begin
        cx <= cx + 10'd1;
      end
      // palette address stage, then palette read stage
      de_pipe <= {de_pipe[0], pre_de};
      fs_pipe <= {fs_pipe[0], pre_fs};
    end
  end

  assign de          = de_pipe[1];
  assign frame_start = fs_pipe[1];

endmodule

// ==== src/super_res_fetch.sv ====
`include "vdp_super_params.svh"

module super_res_fetch
  import vdp_super_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  sr_mode_t   mode,
  input  logic       disp_on,
  input  logic       pal_mode,
  input  beam_t      beam,
  input  vram_word_t vram_rdata,
  output vram_addr_t vram_addr,
  output pal_index_t pal_addr,
  output logic       vram_busy
);

  localparam int last_col = `VDP_VISIBLE_W - 1;
  localparam int preload_col = `VDP_VISIBLE_W + 2;  // rewind address seen by memory at 721

  logic       is_mid;
  logic       fetch_line;  // this line reads memory
  logic       next_fetch;  // next line reads memory
  logic       src_fetch;   // pixel being addressed comes from memory
  logic       line_end;
  logic       next_vis;
  logic       vis_col;
  logic       show;        // next column is on screen
  logic       load;
  logic       lb_wr;
  logic       word_step;
  logic       word_load;
  logic       preload;
  logic       claim;
  logic       odd_phase;
  logic [2:0] phase;
  logic [8:0] lb_idx;
  pal_index_t pix;
  vram_word_t cur_word;
  vram_word_t next_word;
  pal_index_t line_buf [`VDP_MID_LINE_PIX];

  assign is_mid     = (mode == sr_mid);
  assign fetch_line = !is_mid || !beam.cy[0];
  // the last line is even in both frames, and line 0 after it is fetched too
  assign next_fetch = !is_mid || beam.cy[0] || beam.last_line;
  assign line_end   = (beam.cx == frame_width(pal_mode) - 10'd1);
  assign next_vis   = beam.last_line || (beam.cy + 10'd1 < visible_height(pal_mode));
  assign src_fetch  = line_end ? next_fetch : fetch_line;

  assign vis_col = beam.visible_line && (beam.cx < `VDP_VISIBLE_W);
  assign show    = (vis_col && beam.cx != last_col) || (line_end && next_vis);
  assign phase   = {odd_phase, beam.cx[1:0]};

  // current <= next and address step, once per word
  assign word_step = vis_col && fetch_line && beam.cx[1:0] == 2'd0 && !(is_mid && odd_phase);
  // read-ahead word has been on vram_rdata for two columns
  assign word_load = vis_col && fetch_line && beam.cx[1:0] == 2'd3 && (!is_mid || odd_phase);
  assign preload   = beam.last_line && (beam.cx == preload_col);

  assign claim = (beam.cx == `VDP_BUSY_START_X && next_vis && next_fetch) ||
                 (beam.last_line && beam.cx == `VDP_VISIBLE_W);

  // index for the next column
  always_comb begin
    load = 1'b0;
    pix  = line_buf[lb_idx];
    if (line_end) begin
      load = 1'b1;  // pixel 0 of the coming line
      if (src_fetch) begin
        pix = next_word[7:0];
      end
    end else if (!src_fetch) begin
      load = beam.cx[0];  // replay, each entry shown twice
    end else if (is_mid) begin
      load = beam.cx[0];
      case (phase)
        3'b001:  pix = cur_word[15:8];
        3'b011:  pix = cur_word[23:16];
        3'b101:  pix = cur_word[31:24];
        default: pix = vram_rdata[7:0];
      endcase
    end else begin
      load = 1'b1;
      case (beam.cx[1:0])
        2'd0:    pix = next_word[15:8];  // cur_word takes this word on the same edge
        2'd1:    pix = cur_word[23:16];
        2'd2:    pix = cur_word[31:24];
        default: pix = vram_rdata[7:0];
      endcase
    end
  end

  assign lb_wr = show && load && is_mid && src_fetch;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      vram_addr <= '0;
      pal_addr  <= '0;
      lb_idx    <= '0;
      odd_phase <= 1'b0;
      vram_busy <= 1'b0;
    end else if (mode == sr_off) begin
      vram_addr <= '0;
      pal_addr  <= '0;
      lb_idx    <= '0;
      odd_phase <= 1'b0;
      vram_busy <= 1'b0;
    end else begin
      if (!show || !disp_on) begin
        pal_addr <= '0;  // background
      end else if (load) begin
        pal_addr <= pix;
      end

      if (beam.cx == `VDP_VISIBLE_W) begin
        lb_idx <= '0;
      end else if (show && load && is_mid) begin
        lb_idx <= lb_idx + 9'd1;
      end

      // second half of an eight-column super_mid word
      if (beam.cx == `VDP_VISIBLE_W) begin
        odd_phase <= 1'b0;
      end else if (vis_col && beam.cx[1:0] == 2'd3) begin
        odd_phase <= !odd_phase;
      end

      if (beam.last_line && beam.cx == `VDP_VISIBLE_W) begin
        vram_addr <= '0;  // rewind for the new frame
      end else if (word_step) begin
        vram_addr <= vram_addr + 1'b1;
      end

      if (claim) begin
        vram_busy <= 1'b1;
      end else if (beam.cx == `VDP_BUSY_END_X) begin
        vram_busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (word_step) begin
      cur_word <= next_word;
    end
    if (word_load || preload) begin
      next_word <= vram_rdata;
    end
    if (lb_wr) begin
      line_buf[lb_idx] <= pix;
    end
  end

endmodule

// ==== src/host_write_port.sv ====
module host_write_port
  import vdp_super_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      host_req,
  input  host_cmd_t host_cmd,
  output logic      host_ack,
  output wr_req_t   wr
);

  host_state_t state;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= hs_idle;
      host_ack <= 1'b0;
      wr       <= '0;
    end else begin
      wr.en <= 1'b0;  // strobe, one cycle at most
      case (state)
        hs_idle: begin
          if (host_req) begin
            wr.target <= host_cmd.target;
            wr.addr   <= host_cmd.addr;
            wr.data   <= host_cmd.data;
            state     <= hs_write;
          end
        end
        hs_write: begin
          wr.en <= 1'b1;
          state <= hs_ack;
        end
        hs_ack: begin
          // hold ack until the host lets go of req
          if (host_ack && !host_req) begin
            host_ack <= 1'b0;
            state    <= hs_idle;
          end else begin
            host_ack <= 1'b1;
          end
        end
        default: begin
          state <= hs_idle;
        end
      endcase
    end
  end

endmodule

// ==== src/video_memory.sv ====
`include "vdp_super_params.svh"

module video_memory
  import vdp_super_pkg::*;
(
  input  logic       clk,
  input  wr_req_t    wr,
  input  vram_addr_t vram_addr,
  input  pal_index_t pal_addr,
  output vram_word_t vram_rdata,
  output rgb_t       rgb
);

  localparam int vram_words  = 2 ** `VDP_VRAM_AW;
  localparam int pal_entries = 2 ** $bits(pal_index_t);

  vram_word_t vram    [vram_words];
  rgb_t       palette [pal_entries];
  logic       vram_we;
  logic       pal_we;

  assign vram_we = wr.en && (wr.target == tgt_vram);
  assign pal_we  = wr.en && (wr.target == tgt_palette);

  // packed indexes, registered read
  always_ff @(posedge clk) begin
    if (vram_we) begin
      vram[wr.addr] <= wr.data;
    end
    vram_rdata <= vram[vram_addr];
  end

  // palette, only the low address byte counts
  always_ff @(posedge clk) begin
    if (pal_we) begin
      palette[wr.addr[7:0]] <= rgb_t'(wr.data[23:0]);
    end
    rgb <= palette[pal_addr];
  end

endmodule

// ==== src/super_res_video.sv ====
module super_res_video
  import vdp_super_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  sr_mode_t  mode,
  input  logic      pal_mode,    // 1 selects the 50 Hz frame
  input  logic      disp_on,
  input  logic      host_req,
  input  host_cmd_t host_cmd,
  output logic      host_ack,
  output rgb_t      rgb,
  output logic      de,
  output logic      frame_start,
  output logic      vram_busy
);

  beam_t      beam;
  vram_addr_t vram_addr;
  vram_word_t vram_rdata;
  pal_index_t pal_addr;
  wr_req_t    wr;

  raster_timing u_raster (
    .clk         (clk),
    .reset       (reset),
    .pal_mode    (pal_mode),
    .beam        (beam),
    .de          (de),
    .frame_start (frame_start)
  );

  super_res_fetch u_fetch (
    .clk        (clk),
    .reset      (reset),
    .mode       (mode),
    .disp_on    (disp_on),
    .pal_mode   (pal_mode),
    .beam       (beam),
    .vram_rdata (vram_rdata),
    .vram_addr  (vram_addr),
    .pal_addr   (pal_addr),
    .vram_busy  (vram_busy)
  );

  host_write_port u_host (
    .clk      (clk),
    .reset    (reset),
    .host_req (host_req),
    .host_cmd (host_cmd),
    .host_ack (host_ack),
    .wr       (wr)
  );

  video_memory u_mem (
    .clk        (clk),
    .wr         (wr),
    .vram_addr  (vram_addr),
    .pal_addr   (pal_addr),
    .vram_rdata (vram_rdata),
    .rgb        (rgb)
  );

endmodule

// ==== bench/super_res_video_assertions.sv ====
module super_res_video_assertions (
  input logic clk,
  input logic reset,
  input logic host_req,
  input logic host_ack,
  input logic wr_en,
  input logic de
);
  timeunit 1ns;
  timeprecision 1ps;

  // ack only answers a pending request
  ack_rise_on_req: assert property (@(posedge clk) disable iff (reset)
    $rose(host_ack) |-> $past(host_req))
    else $error("host_ack rose without host_req");

  ack_fall_after_req: assert property (@(posedge clk) disable iff (reset)
    $fell(host_ack) |-> !$past(host_req))
    else $error("host_ack fell while host_req was still high");

  de_low_in_reset: assert property (@(posedge clk) reset |-> !de)
    else $error("de high during reset");

  // single strobe per command
  wr_en_one_cycle: assert property (@(posedge clk) disable iff (reset)
    $rose(wr_en) |=> !wr_en)
    else $error("write strobe longer than one cycle");

endmodule

bind super_res_video super_res_video_assertions u_checks (
  .clk      (clk),
  .reset    (reset),
  .host_req (host_req),
  .host_ack (host_ack),
  .wr_en    (wr.en),
  .de       (de)
);

// ==== bench/super_res_video_tb.sv ====
`include "vdp_super_params.svh"

module super_res_video_tb
  import vdp_super_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    sr_mode_t   mode;
    logic       pal_mode;
    logic       disp_on;
    logic [7:0] seed;
    int         frame_cycles;  // expected frame_start spacing
  } scenario_t;

  localparam int num_rows    = 4;
  localparam int check_lines = 16;
  localparam int line_pix    = `VDP_VISIBLE_W;
  localparam int load_words  = check_lines * line_pix / 4;
  localparam int ntsc_frame  = `VDP_FRAME_W_60 * `VDP_FRAME_H_60;
  localparam int pal_frame   = `VDP_FRAME_W_50 * `VDP_FRAME_H_50;
  localparam longint load_cycles = (256 + load_words) * 8;  // one handshake is about 7
  localparam longint watchdog_ns = num_rows * (3 * pal_frame + load_cycles) * 4;

  logic       clk;
  logic       reset;
  sr_mode_t   mode;
  logic       pal_mode;
  logic       disp_on;
  logic       host_req;
  host_cmd_t  host_cmd;
  logic       host_ack;
  rgb_t       rgb;
  logic       de;
  logic       frame_start;
  logic       vram_busy;

  rgb_t       pal_tab  [256];
  vram_word_t vram_tab [load_words];

  scenario_t scen_tab [num_rows] = '{
    '{sr_res, 1'b0, 1'b1, 8'h11, ntsc_frame},
    '{sr_mid, 1'b1, 1'b1, 8'h5a, pal_frame},
    '{sr_res, 1'b1, 1'b0, 8'h93, pal_frame},  // display off, background only
    '{sr_mid, 1'b0, 1'b1, 8'h3c, ntsc_frame}
  };

  super_res_video dut0 (
    .clk         (clk),
    .reset       (reset),
    .mode        (mode),
    .pal_mode    (pal_mode),
    .disp_on     (disp_on),
    .host_req    (host_req),
    .host_cmd    (host_cmd),
    .host_ack    (host_ack),
    .rgb         (rgb),
    .de          (de),
    .frame_start (frame_start),
    .vram_busy   (vram_busy)
  );

  always #2 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] got_val);
    if (exp_val !== got_val) begin
      $display("Mismatch %s exp=%h got=%h", name, exp_val, got_val);
      $display("sim failed");
      $fatal(1, "value check failed");
    end
  endtask

  // four-phase req/ack, one command
  task automatic host_write(input logic tgt, input vram_addr_t addr_in,
                            input vram_word_t data_in);
    @(posedge clk);
    host_cmd <= '{target: tgt, addr: addr_in, data: data_in};
    host_req <= 1'b1;
    while (!host_ack) @(posedge clk);
    host_req <= 1'b0;
    while (host_ack) @(posedge clk);
  endtask

  task automatic load_memory(input logic [7:0] seed);
    rgb_t       color;
    vram_word_t word;
    for (int i = 0; i < 256; i++) begin
      color = rgb_t'($urandom & 32'h00ff_ffff);
      pal_tab[i] = color;
      host_write(tgt_palette, vram_addr_t'(i), {8'h00, color});
    end
    for (int w = 0; w < load_words; w++) begin
      for (int k = 0; k < 4; k++) begin
        word[8*k +: 8] = 8'((4 * w + k) * 7 + seed);  // byte b = b*7 + seed
      end
      vram_tab[w] = word;
      host_write(tgt_vram, vram_addr_t'(w), word);
    end
  endtask

  function automatic rgb_t expected_rgb(input scenario_t row, input int x, input int y);
    int b;
    if (!row.disp_on) begin
      return pal_tab[0];
    end
    if (row.mode == sr_res) begin
      b = y * line_pix + x;
    end else begin
      b = (y / 2) * (line_pix / 2) + x / 2;  // each source pixel doubled both ways
    end
    return pal_tab[vram_tab[b / 4][8 * (b % 4) +: 8]];
  endfunction

  task automatic run_row(input scenario_t row);
    int pix;
    int run_len;
    int period;
    @(posedge clk);
    mode <= sr_off;
    @(posedge clk);
    load_memory(row.seed);
    @(posedge clk);
    mode     <= row.mode;
    pal_mode <= row.pal_mode;
    disp_on  <= row.disp_on;
    // first frame may be partial, measure the next one
    do @(negedge clk); while (!frame_start);
    period = 0;
    do begin
      @(negedge clk);
      period++;
    end while (!frame_start);
    check_value("frame_start period", row.frame_cycles, period);
    check_value("de", 1, de);
    pix     = 0;
    run_len = 0;
    while (pix < check_lines * line_pix) begin
      if (de) begin
        check_value($sformatf("rgb x%0d y%0d", pix % line_pix, pix / line_pix),
                    expected_rgb(row, pix % line_pix, pix / line_pix), rgb);
        // bus held on every line in super_res, on even lines in super_mid
        check_value("vram_busy", (row.mode == sr_res) || ((pix / line_pix) % 2 == 0),
                    vram_busy);
        pix++;
        run_len++;
      end else if (run_len != 0) begin
        check_value("de run length", line_pix, run_len);
        run_len = 0;
      end
      @(negedge clk);
    end
    check_value("de", 0, de);  // nothing after pixel 719 of line 15
  endtask

  initial begin
    clk      = 1'b0;
    reset    = 1'b1;
    mode     = sr_off;
    pal_mode = 1'b0;
    disp_on  = 1'b0;
    host_req = 1'b0;
    host_cmd = '0;
    void'($urandom(32'h65ac));
    repeat (2) @(posedge clk);
    check_value("de", 0, de);
    check_value("frame_start", 0, frame_start);
    check_value("host_ack", 0, host_ack);
    check_value("vram_busy", 0, vram_busy);
    reset <= 1'b0;
    for (int r = 0; r < num_rows; r++) begin
      run_row(scen_tab[r]);
    end
    $display("sim passed");
    $finish;
  end

  initial begin
    #(watchdog_ns * 1ns);
    $display("timeout: the run hung waiting for the DUT");
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== compile.f ====
+incdir+src
src/vdp_super_pkg.sv
src/raster_timing.sv
src/super_res_fetch.sv
src/host_write_port.sv
src/video_memory.sv
src/super_res_video.sv
bench/super_res_video_assertions.sv
bench/super_res_video_tb.sv
